// ==== verilog/siso_pkg.sv ====
package siso_pkg;

	////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////
	localparam int LLR_W         = 16;
	localparam int METRIC_W      = 20;
	localparam int NUM_STATES    = 8;
	localparam int MAX_BLOCK_LEN = 64;
	localparam int ADDR_W        = $clog2(MAX_BLOCK_LEN);
	localparam int EXT_SCALE     = 2;

	typedef logic signed [LLR_W-1:0]    llr_t;
	typedef logic signed [METRIC_W-1:0] metric_t;
	typedef metric_t [NUM_STATES-1:0]   state_metrics_t;
	typedef logic [ADDR_W-1:0]          step_idx_t;

	// starting beta of states 1..7, state 0 starts at zero
	localparam metric_t BETA_INIT_OTHER = metric_t'(-128);

	// trellis connections, shared by beta update and branch sums
	localparam int PLUS_PARTNER [NUM_STATES]  = '{0, 4, 5, 1, 2, 6, 7, 3};
	localparam int MINUS_PARTNER [NUM_STATES] = '{4, 0, 1, 5, 6, 2, 3, 7};

	////////////////////////////////////////
	// records
	////////////////////////////////////////
	typedef struct packed {
		llr_t           sys;
		llr_t           apriori;
		llr_t           gamma1;
		llr_t           gamma2;
		state_metrics_t alpha;
	} trellis_step_t;

	// step plus the beta of the following step
	typedef struct packed {
		trellis_step_t  step;
		state_metrics_t beta;
		step_idx_t      idx;
	} beta_step_t;

	typedef struct packed {
		llr_t      ext;
		step_idx_t idx;
	} ext_out_t;

	typedef enum logic [1:0] {PH_IDLE, PH_LOAD, PH_DECODE} phase_t;

	function automatic metric_t max_metric(metric_t a, metric_t b);
		return (a > b) ? a : b;
	endfunction

	// states 2..5 take gamma2, the rest gamma1
	function automatic metric_t branch_of(trellis_step_t st, int s);
		metric_t g;
		if (s >= 2 && s <= 5)
			g = metric_t'(st.gamma2);
		else
			g = metric_t'(st.gamma1);
		return g;
	endfunction

endpackage

// ==== verilog/siso_control.sv ====
module siso_control (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      blk_len_valid_i,
	input  logic [siso_pkg::ADDR_W:0] blk_len_i,
	input  logic                      sym_valid_i,
	output logic                      ready_o,
	output logic                      wr_en_o,
	output siso_pkg::step_idx_t       wr_addr_o,
	output logic                      rd_en_o,
	output siso_pkg::step_idx_t       rd_addr_o,
	output logic                      block_start_o,
	input  logic                      drain_done_i
);
	import siso_pkg::*;

	phase_t    phase;
	step_idx_t len_m1;
	step_idx_t wr_cnt;
	step_idx_t rd_cnt;
	logic      rd_busy;
	logic      start_q;
	logic      sym_beat;
	logic      last_beat;

	// symbols are only taken while loading
	assign sym_beat  = sym_valid_i && ready_o && (phase == PH_LOAD);
	assign last_beat = sym_beat && (wr_cnt == len_m1);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase   <= PH_IDLE;
			len_m1  <= '0;
			wr_cnt  <= '0;
			rd_cnt  <= '0;
			rd_busy <= 1'b0;
			start_q <= 1'b0;
		end else begin
			start_q <= last_beat;
			case (phase)
				PH_IDLE: begin
					if (blk_len_valid_i) begin
						len_m1 <= step_idx_t'(blk_len_i - 1'b1);
						wr_cnt <= '0;
						phase  <= PH_LOAD;
					end
				end
				PH_LOAD: begin
					if (sym_beat)
						wr_cnt <= wr_cnt + 1'b1;
					// reads start right after the last beat, top step first
					if (last_beat) begin
						rd_cnt  <= len_m1;
						rd_busy <= 1'b1;
						phase   <= PH_DECODE;
					end
				end
				PH_DECODE: begin
					if (rd_busy) begin
						rd_cnt <= rd_cnt - 1'b1;
						if (rd_cnt == '0)
							rd_busy <= 1'b0;
					end
					if (drain_done_i)
						phase <= PH_IDLE;
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	assign ready_o       = (phase != PH_DECODE);
	assign wr_en_o       = sym_beat;
	assign wr_addr_o     = wr_cnt;
	assign rd_en_o       = rd_busy;
	assign rd_addr_o     = rd_cnt;
	assign block_start_o = start_q;

endmodule

// ==== verilog/trellis_store.sv ====
module trellis_store (
	input  logic                     clk,
	input  logic                     wr_en_i,
	input  siso_pkg::step_idx_t      wr_addr_i,
	input  siso_pkg::trellis_step_t  wr_data_i,
	input  logic                     rd_en_i,
	input  siso_pkg::step_idx_t      rd_addr_i,
	output siso_pkg::trellis_step_t  rd_data_o,
	output logic                     rd_valid_o,
	output siso_pkg::step_idx_t      rd_idx_o
);
	import siso_pkg::*;

	trellis_step_t mem [MAX_BLOCK_LEN];

	////////////////////////////////////////
	// write port, load phase only
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	////////////////////////////////////////
	// registered read port
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rd_en_i)
			rd_data_o <= mem[rd_addr_i];
	end

	// flag and index follow the data by one cycle
	always_ff @(posedge clk) begin
		rd_valid_o <= rd_en_i;
		rd_idx_o   <= rd_addr_i;
	end

endmodule

// ==== verilog/beta_recursion.sv ====
module beta_recursion (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     block_start_i,
	input  logic                     step_valid_i,
	input  siso_pkg::trellis_step_t  step_i,
	input  siso_pkg::step_idx_t      step_idx_i,
	output logic                     out_valid_o,
	output siso_pkg::beta_step_t     out_o
);
	import siso_pkg::*;

	state_metrics_t beta_q;
	state_metrics_t beta_upd;
	state_metrics_t beta_norm;

	////////////////////////////////////////
	// butterfly and normalization
	////////////////////////////////////////
	always_comb begin
		metric_t g;
		for (int s = 0; s < NUM_STATES; s++) begin
			g = branch_of(step_i, s);
			beta_upd[s] = max_metric(beta_q[PLUS_PARTNER[s]] + g,
				beta_q[MINUS_PARTNER[s]] - g);
		end
		// keep state 0 at zero so the metrics stay bounded
		for (int s = 0; s < NUM_STATES; s++)
			beta_norm[s] = beta_upd[s] - beta_upd[0];
	end

	always_ff @(posedge clk) begin
		if (block_start_i) begin
			for (int s = 0; s < NUM_STATES; s++)
				beta_q[s] <= (s == 0) ? '0 : BETA_INIT_OTHER;
		end else if (step_valid_i) begin
			beta_q <= beta_norm;
		end
	end

	////////////////////////////////////////
	// hand-off to the llr stage
	////////////////////////////////////////

	// step goes out with the beta it was reached from
	always_ff @(posedge clk) begin
		if (step_valid_i) begin
			out_o.step <= step_i;
			out_o.beta <= beta_q;
			out_o.idx  <= step_idx_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			out_valid_o <= 1'b0;
		else
			out_valid_o <= step_valid_i;
	end

endmodule

// ==== verilog/llr_extrinsic.sv ====
module llr_extrinsic (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid_i,
	input  siso_pkg::beta_step_t  in_i,
	output logic                  ext_valid_o,
	output siso_pkg::ext_out_t    ext_o
);
	import siso_pkg::*;

	typedef struct packed {
		llr_t      sys;
		llr_t      apriori;
		step_idx_t idx;
	} side_t;

	metric_t minus_sum [NUM_STATES];
	metric_t plus_sum  [NUM_STATES];
	metric_t minus_q   [NUM_STATES];
	metric_t plus_q    [NUM_STATES];
	metric_t minus_l1  [NUM_STATES/2];
	metric_t plus_l1   [NUM_STATES/2];
	metric_t minus_l2_q [2];
	metric_t plus_l2_q  [2];
	metric_t llr;
	metric_t diff;
	metric_t scaled;
	side_t   side1_q;
	side_t   side2_q;
	logic [2:0] valid_q;

	////////////////////////////////////////
	// stage 1: branch sums
	////////////////////////////////////////
	always_comb begin
		metric_t g;
		for (int s = 0; s < NUM_STATES; s++) begin
			g = branch_of(in_i.step, s);
			minus_sum[s] = in_i.step.alpha[s] - g + in_i.beta[MINUS_PARTNER[s]];
			plus_sum[s]  = in_i.step.alpha[s] + g + in_i.beta[PLUS_PARTNER[s]];
		end
	end

	always_ff @(posedge clk) begin
		minus_q         <= minus_sum;
		plus_q          <= plus_sum;
		side1_q.sys     <= in_i.step.sys;
		side1_q.apriori <= in_i.step.apriori;
		side1_q.idx     <= in_i.idx;
	end

	////////////////////////////////////////
	// stage 2: first two max levels
	////////////////////////////////////////
	always_comb begin
		for (int k = 0; k < NUM_STATES/2; k++) begin
			minus_l1[k] = max_metric(minus_q[2*k], minus_q[2*k+1]);
			plus_l1[k]  = max_metric(plus_q[2*k], plus_q[2*k+1]);
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < 2; k++) begin
			minus_l2_q[k] <= max_metric(minus_l1[2*k], minus_l1[2*k+1]);
			plus_l2_q[k]  <= max_metric(plus_l1[2*k], plus_l1[2*k+1]);
		end
		side2_q <= side1_q;
	end

	////////////////////////////////////////
	// stage 3: llr and extrinsic
	////////////////////////////////////////
	always_comb begin
		llr = max_metric(minus_l2_q[0], minus_l2_q[1])
			- max_metric(plus_l2_q[0], plus_l2_q[1]);
		diff   = llr - metric_t'(side2_q.sys) - metric_t'(side2_q.apriori);
		scaled = metric_t'(diff * EXT_SCALE);
	end

	// extrinsic wraps to the llr width
	always_ff @(posedge clk) begin
		ext_o.ext <= llr_t'(scaled);
		ext_o.idx <= side2_q.idx;
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= '0;
		else
			valid_q <= {valid_q[1:0], in_valid_i};
	end

	assign ext_valid_o = valid_q[2];

endmodule

// ==== verilog/beta_llr_top.sv ====
module beta_llr_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      blk_len_valid_i,
	input  logic [siso_pkg::ADDR_W:0] blk_len_i,
	input  logic                      sym_valid_i,
	input  siso_pkg::trellis_step_t   sym_i,
	output logic                      ready_o,
	output logic                      ext_valid_o,
	output siso_pkg::ext_out_t        ext_o
);
	import siso_pkg::*;

	logic          wr_en;
	step_idx_t     wr_addr;
	logic          rd_en;
	step_idx_t     rd_addr;
	logic          block_start;
	logic          drain_done;
	trellis_step_t rd_data;
	logic          rd_valid;
	step_idx_t     rd_idx;
	logic          beta_valid;
	beta_step_t    beta_step;

	// index 0 leaves last, block is then fully drained
	assign drain_done = ext_valid_o && (ext_o.idx == '0);

	siso_control siso_control_inst (
		.clk(clk), .rst(rst),
		.blk_len_valid_i(blk_len_valid_i), .blk_len_i(blk_len_i),
		.sym_valid_i(sym_valid_i), .ready_o(ready_o),
		.wr_en_o(wr_en), .wr_addr_o(wr_addr),
		.rd_en_o(rd_en), .rd_addr_o(rd_addr),
		.block_start_o(block_start), .drain_done_i(drain_done)
	);

	trellis_store trellis_store_inst (
		.clk(clk),
		.wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(sym_i),
		.rd_en_i(rd_en), .rd_addr_i(rd_addr),
		.rd_data_o(rd_data), .rd_valid_o(rd_valid), .rd_idx_o(rd_idx)
	);

	beta_recursion beta_recursion_inst (
		.clk(clk), .rst(rst),
		.block_start_i(block_start),
		.step_valid_i(rd_valid), .step_i(rd_data), .step_idx_i(rd_idx),
		.out_valid_o(beta_valid), .out_o(beta_step)
	);

	llr_extrinsic llr_extrinsic_inst (
		.clk(clk), .rst(rst),
		.in_valid_i(beta_valid), .in_i(beta_step),
		.ext_valid_o(ext_valid_o), .ext_o(ext_o)
	);

endmodule

// ==== testbench/beta_llr_asserts.sv ====
module beta_llr_asserts (
	input logic clk,
	input logic rst,
	input logic ready_i,
	input logic ext_valid_i,
	input logic blk_len_valid_i,
	input logic wr_en_i
);

	// open from length accept until decode starts
	logic len_open;

	always_ff @(posedge clk) begin
		if (rst)
			len_open <= 1'b0;
		else if (!ready_i)
			len_open <= 1'b0;
		else if (blk_len_valid_i)
			len_open <= 1'b1;
	end

	no_result_while_ready: assert property (@(posedge clk) disable iff (rst)
		ext_valid_i |-> !ready_i)
		else $error("ext_valid_o high while ready_o is high");

	ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> ready_i)
		else $error("ready_o low in the cycle after reset");

	beat_needs_length: assert property (@(posedge clk) disable iff (rst)
		wr_en_i |-> len_open)
		else $error("symbol beat accepted before a block length");

endmodule

bind beta_llr_top beta_llr_asserts beta_llr_asserts_inst (
	.clk(clk), .rst(rst), .ready_i(ready_o), .ext_valid_i(ext_valid_o),
	.blk_len_valid_i(blk_len_valid_i), .wr_en_i(wr_en)
);

// ==== testbench/beta_llr_tb.sv ====
module beta_llr_tb;
	import siso_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY  = 4;
	localparam int WAIT_LIMIT = 400;
	localparam int MINUS_FROM [NUM_STATES] = '{4, 0, 1, 5, 6, 2, 3, 7};
	localparam int PLUS_FROM [NUM_STATES]  = '{0, 4, 5, 1, 2, 6, 7, 3};

	logic            clk;
	logic            rst;
	logic            blk_len_valid_i;
	logic [ADDR_W:0] blk_len_i;
	logic            sym_valid_i;
	trellis_step_t   sym_i;
	logic            ready_o;
	logic            ext_valid_o;
	ext_out_t        ext_o;

	logic [31:0]   lfsr_q;
	trellis_step_t blk [MAX_BLOCK_LEN];
	llr_t          exp_ext [MAX_BLOCK_LEN];

	beta_llr_top beta_llr_top_inst (
		.clk(clk), .rst(rst),
		.blk_len_valid_i(blk_len_valid_i), .blk_len_i(blk_len_i),
		.sym_valid_i(sym_valid_i), .sym_i(sym_i), .ready_o(ready_o),
		.ext_valid_o(ext_valid_o), .ext_o(ext_o)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	////////////////////////////////////////
	// failure reporting and compares
	////////////////////////////////////////
	task automatic abort_run(input string line);
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_ext(input ext_out_t got, input ext_out_t want, input string what);
		if (got !== want)
			abort_run($sformatf("ERROR at %0t: %s: got ext %0d idx %0d, expected ext %0d idx %0d",
				$time, what, got.ext, got.idx, want.ext, want.idx));
	endtask

	task automatic check_ready(input logic got, input logic want, input string what);
		if (got !== want)
			abort_run($sformatf("ERROR at %0t: %s is %b, expected %b", $time, what, got, want));
	endtask

	task automatic check_valid(input logic got, input logic want, input string what);
		if (got !== want)
			abort_run($sformatf("ERROR at %0t: %s is %b, expected %b", $time, what, got, want));
	endtask

	// inputs change and outputs are read just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	////////////////////////////////////////
	// random stimulus
	////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		else
			return s >> 1;
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// sign bit taken after the magnitude for a symmetric range
	function automatic int rand_signed(input int mag_bits);
		int mag;
		mag = int'(rand_bits(mag_bits));
		if (rand_bits(1) != 0)
			return -mag;
		else
			return mag;
	endfunction

	task automatic fill_block(input int n);
		for (int i = 0; i < n; i++) begin
			blk[i].sys     = llr_t'(rand_signed(9));
			blk[i].apriori = llr_t'(rand_signed(9));
			blk[i].gamma1  = llr_t'(rand_signed(9));
			blk[i].gamma2  = llr_t'(rand_signed(9));
			for (int s = 0; s < NUM_STATES; s++)
				blk[i].alpha[s] = metric_t'(rand_signed(11));
		end
	endtask

	////////////////////////////////////////
	// reference model walking from the last step
	////////////////////////////////////////
	function automatic metric_t max_of(input metric_t a, input metric_t b);
		return (a > b) ? a : b;
	endfunction

	task automatic build_expected(input int n);
		metric_t beta [NUM_STATES];
		metric_t nb [NUM_STATES];
		metric_t g1;
		metric_t g2;
		metric_t g;
		metric_t alpha_s;
		metric_t sum_minus;
		metric_t sum_plus;
		metric_t best_minus;
		metric_t best_plus;
		metric_t llr;
		llr_t    raw;
		int      diff;
		for (int s = 0; s < NUM_STATES; s++)
			beta[s] = (s == 0) ? metric_t'(0) : BETA_INIT_OTHER;
		best_minus = '0;
		best_plus = '0;
		for (int k = n - 1; k >= 0; k--) begin
			raw = blk[k].gamma1;
			g1 = raw;
			raw = blk[k].gamma2;
			g2 = raw;
			for (int s = 0; s < NUM_STATES; s++) begin
				g = (s >= 2 && s <= 5) ? g2 : g1;
				alpha_s = blk[k].alpha[s];
				sum_minus = alpha_s - g + beta[MINUS_FROM[s]];
				sum_plus = alpha_s + g + beta[PLUS_FROM[s]];
				if (s == 0 || sum_minus > best_minus)
					best_minus = sum_minus;
				if (s == 0 || sum_plus > best_plus)
					best_plus = sum_plus;
			end
			llr = best_minus - best_plus;
			raw = blk[k].sys;
			diff = int'(llr) - int'(raw);
			raw = blk[k].apriori;
			diff = diff - int'(raw);
			exp_ext[k] = llr_t'(diff * EXT_SCALE);
			nb[0] = max_of(beta[0] + g1, beta[4] - g1);
			nb[1] = max_of(beta[4] + g1, beta[0] - g1);
			nb[2] = max_of(beta[5] + g2, beta[1] - g2);
			nb[3] = max_of(beta[1] + g2, beta[5] - g2);
			nb[4] = max_of(beta[2] + g2, beta[6] - g2);
			nb[5] = max_of(beta[6] + g2, beta[2] - g2);
			nb[6] = max_of(beta[7] + g1, beta[3] - g1);
			nb[7] = max_of(beta[3] + g1, beta[7] - g1);
			for (int s = 0; s < NUM_STATES; s++)
				beta[s] = nb[s] - nb[0];
		end
	endtask

	////////////////////////////////////////
	// one block through length, load and drain
	////////////////////////////////////////
	task automatic run_block(input int n);
		int       cyc;
		int       sent;
		logic     beat;
		ext_out_t want;
		build_expected(n);
		cyc = 0;
		while (!ready_o) begin
			next_cycle();
			cyc++;
			if (cyc > WAIT_LIMIT)
				abort_run("timeout: the DUT never became ready for a block length");
		end
		blk_len_valid_i = 1'b1;
		blk_len_i = (ADDR_W+1)'(n);
		// a symbol offered in idle must not be taken
		sym_valid_i = 1'b1;
		sym_i = ~blk[0];
		next_cycle();
		blk_len_valid_i = 1'b0;
		sym_valid_i = 1'b0;
		sent = 0;
		cyc = 0;
		while (sent < n) begin
			beat = (rand_bits(2) != 0);
			sym_valid_i = beat;
			sym_i = blk[sent];
			check_ready(ready_o, 1'b1, "ready_o during load");
			next_cycle();
			if (beat)
				sent++;
			cyc++;
			if (cyc > 8 * MAX_BLOCK_LEN)
				abort_run("timeout: the symbol load did not finish");
		end
		sym_valid_i = 1'b0;
		// count cycles from the last load beat to the first result
		cyc = 0;
		while (!ext_valid_o) begin
			check_ready(ready_o, 1'b0, "ready_o during decode");
			next_cycle();
			cyc++;
			if (cyc > WAIT_LIMIT)
				abort_run("timeout: no result came out of the decoder");
		end
		if (cyc != 5)
			abort_run($sformatf("ERROR at %0t: first result after %0d cycles, expected 5",
				$time, cyc));
		for (int k = n - 1; k >= 0; k--) begin
			check_valid(ext_valid_o, 1'b1, "ext_valid_o within a block");
			check_ready(ready_o, 1'b0, "ready_o while results drain");
			want.ext = exp_ext[k];
			want.idx = step_idx_t'(k);
			check_ext(ext_o, want, "extrinsic result");
			next_cycle();
		end
		check_valid(ext_valid_o, 1'b0, "ext_valid_o after the last result");
		check_ready(ready_o, 1'b1, "ready_o after the last result");
	endtask

	initial begin
		int n;
		clk = 1'b0;
		rst = 1'b1;
		blk_len_valid_i = 1'b0;
		blk_len_i = '0;
		sym_valid_i = 1'b0;
		sym_i = '0;
		lfsr_q = 32'hc014fb0b;
		repeat (16) next_cycle();
		rst = 1'b0;
		next_cycle();
		check_ready(ready_o, 1'b1, "ready_o after reset");
		check_valid(ext_valid_o, 1'b0, "ext_valid_o after reset");
		// single step decoded from the initial betas
		fill_block(1);
		run_block(1);
		repeat (20) begin
			n = int'(rand_bits(6)) + 1;
			fill_block(n);
			run_block(n);
		end
		// full block followed straight away by another
		fill_block(MAX_BLOCK_LEN);
		run_block(MAX_BLOCK_LEN);
		n = int'(rand_bits(6)) + 1;
		fill_block(n);
		run_block(n);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== siso_beta_llr.f ====
verilog/siso_pkg.sv
verilog/siso_control.sv
verilog/trellis_store.sv
verilog/beta_recursion.sv
verilog/llr_extrinsic.sv
verilog/beta_llr_top.sv
testbench/beta_llr_asserts.sv
testbench/beta_llr_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the beta/llr testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert \
	--top-module beta_llr_tb \
	-f siso_beta_llr.f \
	-o sim_beta_llr
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_beta_llr > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -qF '*** TEST FAILED ***' "$log_file"; then
	echo "simulation failed, see $log_file"
	exit 1
fi
if [ $run_status -ne 0 ] || ! grep -qF '*** TEST PASSED ***' "$log_file"; then
	echo "simulation ended abnormally with status $run_status"
	exit 1
fi
exit 0
